/* int_core_top.f */
verilog/rv_pkg.sv
verilog/inst_decoder.sv
verilog/decode_stage.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/int_core_top.sv
verif/tb_int_core.sv

/* Makefile */
TOP = tb_int_core

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f int_core_top.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TESTBENCH PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* verif/tb_int_core.sv */
// directed testbench for the integer slice: reference register model, encoders, retire checker
`timescale 1ns/1ps
`default_nettype none

module tb_int_core
    import rv_pkg::*;
();

    logic            clk;
    logic            rst;
    logic            in_valid;
    fetch_t          in_fetch;
    retire_t         retire;

    logic [xlen-1:0] model [nreg];   // architectural register state
    retire_t         exp_q [$];      // retire records still outstanding
    retire_t         exp_head;
    logic [xlen-1:0] pc_ctr = 64'h8000_0000;
    int              seed = 32'h7cf9fc79;
    int              pushed = 0;
    int              cycles = 0;

    int_core_top DUT (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_fetch (in_fetch),
        .retire   (retire)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic void fail_run(string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endfunction

    task automatic compare_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [63:0] sext32(logic [63:0] x);
        return {{32{x[31]}}, x[31:0]};
    endfunction

    // {funct7, funct3, opcode} per mnemonic
    function automatic logic [16:0] fields(string m);
        case (m)
            "add":   return {7'h00, 3'd0, 7'h33};
            "sub":   return {7'h20, 3'd0, 7'h33};
            "sll":   return {7'h00, 3'd1, 7'h33};
            "slt":   return {7'h00, 3'd2, 7'h33};
            "sltu":  return {7'h00, 3'd3, 7'h33};
            "xor":   return {7'h00, 3'd4, 7'h33};
            "srl":   return {7'h00, 3'd5, 7'h33};
            "sra":   return {7'h20, 3'd5, 7'h33};
            "or":    return {7'h00, 3'd6, 7'h33};
            "and":   return {7'h00, 3'd7, 7'h33};
            "addw":  return {7'h00, 3'd0, 7'h3b};
            "subw":  return {7'h20, 3'd0, 7'h3b};
            "sllw":  return {7'h00, 3'd1, 7'h3b};
            "srlw":  return {7'h00, 3'd5, 7'h3b};
            "sraw":  return {7'h20, 3'd5, 7'h3b};
            "addi":  return {7'h00, 3'd0, 7'h13};
            "slli":  return {7'h00, 3'd1, 7'h13};
            "srli":  return {7'h00, 3'd5, 7'h13};
            "srai":  return {7'h20, 3'd5, 7'h13};
            "addiw": return {7'h00, 3'd0, 7'h1b};
            "slliw": return {7'h00, 3'd1, 7'h1b};
            "srliw": return {7'h00, 3'd5, 7'h1b};
            "sraiw": return {7'h20, 3'd5, 7'h1b};
            default: begin
                fail_run({"no encoding known for mnemonic ", m});
                return '0;
            end
        endcase
    endfunction

    // RV64I result for one mnemonic, b is rs2 or the sign-extended immediate
    function automatic logic [63:0] ref_result(string m, logic [63:0] a, logic [63:0] b);
        logic signed [31:0] lo;
        lo = a[31:0];
        case (m)
            "add", "addi":   return a + b;
            "sub":           return a - b;
            "sll", "slli":   return a << b[5:0];
            "slt":           return {63'd0, $signed(a) < $signed(b)};
            "sltu":          return {63'd0, a < b};
            "xor":           return a ^ b;
            "srl", "srli":   return a >> b[5:0];
            "sra", "srai":   return $signed(a) >>> b[5:0];
            "or":            return a | b;
            "and":           return a & b;
            "addw", "addiw": return sext32(a + b);
            "subw":          return sext32(a - b);
            "sllw", "slliw": return sext32(a << b[4:0]);
            "srlw", "srliw": return sext32({32'd0, a[31:0] >> b[4:0]});
            "sraw", "sraiw": return sext32({32'd0, lo >>> b[4:0]});
            default:         return '0;
        endcase
    endfunction

    // present one instruction for a single cycle and queue its retire record
    task automatic issue(logic [31:0] inst, int rd, logic [63:0] value, sys_e sys,
                         logic illegal);
        retire_t e;
        e         = '0;
        e.valid   = 1'b1;
        e.pc      = pc_ctr;
        e.rd      = 5'(rd);
        e.wen     = !illegal && sys == sys_none && rd != 0;
        e.value   = value;
        e.sys     = sys;
        e.illegal = illegal;
        if (e.wen) begin
            model[e.rd] = value;
        end
        exp_q.push_back(e);
        pushed++;
        in_valid      = 1'b1;
        in_fetch.pc   = pc_ctr;
        in_fetch.inst = inst;
        pc_ctr        = pc_ctr + 64'd4;
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic op_rr(string m, int rd, int rs1, int rs2);
        logic [16:0] f;
        f = fields(m);
        issue({f[16:10], 5'(rs2), 5'(rs1), f[9:7], 5'(rd), f[6:0]}, rd,
              ref_result(m, model[5'(rs1)], model[5'(rs2)]), sys_none, 1'b0);
    endtask

    task automatic op_ri(string m, int rd, int rs1, logic [11:0] imm);
        logic [16:0] f;
        logic [11:0] imm_f;
        f     = fields(m);
        imm_f = imm;
        if (f[9:7] == 3'd1 || f[9:7] == 3'd5) begin
            imm_f = {f[16:11], imm[5:0]};   // shift: funct7 bits above shamt
        end
        issue({imm_f, 5'(rs1), f[9:7], 5'(rd), f[6:0]}, rd,
              ref_result(m, model[5'(rs1)], {{52{imm_f[11]}}, imm_f}), sys_none, 1'b0);
    endtask

    task automatic op_u(bit auipc, int rd, logic [19:0] imm20);
        logic [63:0] v;
        v = {{32{imm20[19]}}, imm20, 12'd0};
        if (auipc) begin
            v = v + pc_ctr;
        end
        issue({imm20, 5'(rd), auipc ? 7'h17 : 7'h37}, rd, v, sys_none, 1'b0);
    endtask

    task automatic build_values();
        logic [31:0] r;
        for (int k = 1; k <= 4; k++) begin
            r = $random(seed);
            op_u(1'b0, k, r[31:12]);
            op_ri("addi", k, k, r[11:0]);
            r = $random(seed);
            op_ri("slli", k, k, 12'(16 + r[3:0]));
            op_ri("addi", k, k, r[27:16]);
            idle(1);
        end
        for (int k = 5; k <= 8; k++) begin
            r = $random(seed);
            op_u(1'b1, k, r[19:0]);
        end
        op_u(1'b0, 9, 20'h80000);   // negative operand for compares
    endtask

    task automatic rtype_ops();
        string       modes [10] = '{"add", "sub", "sll", "slt", "sltu",
                                    "xor", "srl", "sra", "or", "and"};
        logic [31:0] r;
        for (int i = 0; i < 20; i++) begin
            r = $random(seed);
            op_rr(modes[i % 10], 10 + i % 10, 1 + int'(r[2:0]) + int'(r[3]),
                  1 + int'(r[6:4]) + int'(r[7]));
        end
        op_rr("slt", 21, 9, 5);
        op_rr("sltu", 22, 9, 5);
        op_rr("slt", 23, 5, 9);
        op_rr("sra", 20, 9, 1);   // large rs2, low 6 bits only
    endtask

    task automatic word_ops();
        string       modes [5] = '{"addw", "subw", "sllw", "srlw", "sraw"};
        logic [31:0] r;
        for (int i = 0; i < 10; i++) begin
            r = $random(seed);
            op_rr(modes[i % 5], 11 + i, 1 + int'(r[2:0]) + int'(r[3]),
                  1 + int'(r[6:4]) + int'(r[7]));
        end
        r = $random(seed);
        op_ri("addiw", 21, 1, r[11:0]);
        op_ri("slliw", 22, 2, 12'(r[16:12]));
        op_ri("srliw", 23, 9, 12'(r[21:17]));
        op_ri("sraiw", 24, 9, 12'(r[26:22]));
        op_ri("slli", 25, 3, 12'(r[31:26]));
        r = $random(seed);
        op_ri("srli", 26, 9, 12'(r[5:0]));
        op_ri("srai", 27, 4, 12'(r[11:6]));
        op_ri("srai", 28, 9, 12'(r[17:12]));
    endtask

    // every instruction reads the rd written one cycle earlier
    task automatic dependent_chain();
        logic [31:0] r;
        int          cur;
        int          nxt;
        cur = 24;
        r   = $random(seed);
        op_ri("addi", cur, 0, r[11:0]);
        for (int i = 0; i < 16; i++) begin
            r   = $random(seed);
            nxt = (cur == 24) ? 25 : 24;
            case (i % 4)
                0:       op_rr("add", nxt, cur, 1 + i % 8);
                1:       op_ri("addiw", nxt, cur, r[11:0]);
                2:       op_rr("sll", nxt, 1 + i % 8, cur);
                default: op_ri("srai", nxt, cur, 12'(r[5:0]));
            endcase
            cur = nxt;
        end
    endtask

    task automatic non_writing();
        issue(32'h0000_0073, 0, '0, sys_ecall, 1'b0);
        issue(32'h0010_0073, 0, '0, sys_ebreak, 1'b0);
        issue(32'h3020_0073, 0, '0, sys_mret, 1'b0);
        idle(1);
        issue({7'd0, 5'd2, 5'd1, 3'd0, 5'd8, 7'h63}, 0, '0, sys_none, 1'b1);    // beq
        issue({12'd0, 5'd1, 3'd3, 5'd5, 7'h03}, 0, '0, sys_none, 1'b1);        // ld
        issue({7'h01, 5'd2, 5'd1, 3'd0, 5'd6, 7'h33}, 0, '0, sys_none, 1'b1);  // mul
        op_ri("addi", 0, 3, 12'h123);
        op_rr("add", 26, 0, 0);
        op_rr("or", 27, 0, 3);
    endtask

    task automatic wait_for_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(posedge clk);   // catch stray retires
    endtask

    always @(negedge clk) begin
        if (!rst && retire.valid) begin
            if (exp_q.size() == 0) begin
                fail_run("a retire was reported with no instruction outstanding");
            end else begin
                exp_head = exp_q.pop_front();
                compare_value("retire.pc", retire.pc, exp_head.pc);
                compare_value("retire.wen", 64'(retire.wen), 64'(exp_head.wen));
                compare_value("retire.sys", 64'(retire.sys), 64'(exp_head.sys));
                compare_value("retire.illegal", 64'(retire.illegal), 64'(exp_head.illegal));
                if (exp_head.wen) begin
                    compare_value("retire.rd", 64'(retire.rd), 64'(exp_head.rd));
                    compare_value("retire.value", retire.value, exp_head.value);
                end
            end
        end
    end

    // each instruction takes one cycle to issue and one to retire
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > 2 * pushed + 50) begin
            fail_run("timed out waiting for instructions to retire");
        end
    end

    initial begin
        for (int i = 0; i < nreg; i++) begin
            model[i] = '0;
        end
        rst      = 1'b1;
        in_valid = 1'b0;
        in_fetch = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        idle(8);   // nothing may retire here
        build_values();
        rtype_ops();
        word_ops();
        dependent_chain();
        non_writing();
        wait_for_drain();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/int_core_top.sv */
// top level of the integer slice: decode stage, register file and execute unit
`timescale 1ns/1ps
`default_nettype none

module int_core_top
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  fetch_t  in_fetch,
    output retire_t retire
);

    logic [reg_idx_w-1:0] rs1_addr;
    logic [reg_idx_w-1:0] rs2_addr;
    logic [xlen-1:0]      rs1_data;
    logic [xlen-1:0]      rs2_data;
    exec_t                exec;
    wb_t                  wb;

    decode_stage u_decode (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_fetch (in_fetch),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .exec     (exec)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    exec_unit u_exec (
        .clk    (clk),
        .rst    (rst),
        .exec   (exec),
        .wb     (wb),
        .retire (retire)
    );

endmodule

`default_nettype wire

/* verilog/exec_unit.sv */
// execute unit: 64-bit ALU with word ops, write-back port and retire register
`timescale 1ns/1ps
`default_nettype none

module exec_unit
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  exec_t   exec,
    output wb_t     wb,
    output retire_t retire
);

    logic [xlen-1:0] a_ext;
    logic [5:0]      sh;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] result;

    // word ops see a 32-bit source, srlw must not shift in sign bits
    always_comb begin
        if (!exec.word_op) begin
            a_ext = exec.a;
        end else if (exec.alu_mode == alu_srl) begin
            a_ext = {{(xlen-32){1'b0}}, exec.a[31:0]};
        end else begin
            a_ext = {{(xlen-32){exec.a[31]}}, exec.a[31:0]};
        end
        sh = exec.word_op ? {1'b0, exec.b[4:0]} : exec.b[5:0];
    end

    always_comb begin
        case (exec.alu_mode)
            alu_add:  alu_out = a_ext + exec.b;
            alu_sub:  alu_out = a_ext - exec.b;
            alu_sll:  alu_out = a_ext << sh;
            alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(a_ext) < $signed(exec.b)};
            alu_sltu: alu_out = {{(xlen-1){1'b0}}, a_ext < exec.b};
            alu_xor:  alu_out = a_ext ^ exec.b;
            alu_srl:  alu_out = a_ext >> sh;
            alu_sra:  alu_out = $signed(a_ext) >>> sh;
            alu_or:   alu_out = a_ext | exec.b;
            alu_and:  alu_out = a_ext & exec.b;
            default:  alu_out = '0;
        endcase
    end

    assign result = exec.word_op ? {{(xlen-32){alu_out[31]}}, alu_out[31:0]} : alu_out;

    // written at the same edge that retires the instruction
    assign wb.en   = exec.valid & exec.writes_rd;
    assign wb.addr = exec.rd;
    assign wb.data = result;

    always_ff @(posedge clk) begin
        retire.pc    <= exec.pc;
        retire.rd    <= exec.rd;
        retire.value <= result;
        if (rst) begin
            retire.valid   <= 1'b0;
            retire.wen     <= 1'b0;
            retire.sys     <= sys_none;
            retire.illegal <= 1'b0;
        end else begin
            retire.valid   <= exec.valid;
            retire.wen     <= wb.en;
            retire.sys     <= exec.sys;
            retire.illegal <= exec.illegal;
        end
    end

    // system instructions retire without touching the register file
    sys_no_write: assert property (@(posedge clk) disable iff (rst)
        wb.en |-> exec.sys == sys_none)
        else $error("system instruction requested a write-back");

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
// 32 x 64-bit integer register file, two async read ports, one sync write port
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import rv_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [reg_idx_w-1:0] rs1_addr,
    input  logic [reg_idx_w-1:0] rs2_addr,
    input  wb_t                  wb,
    output logic [xlen-1:0]      rs1_data,
    output logic [xlen-1:0]      rs2_data
);

    logic [xlen-1:0] regs [nreg];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < nreg; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // x0 is hardwired
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // decode drops writes to x0, so none should arrive here
    no_x0_write: assert property (@(posedge clk) disable iff (rst)
        wb.en |-> wb.addr != '0)
        else $error("write-back to x0 requested");

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
// decode stage: fetch register, decoder, operand muxing and execute bundle
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import rv_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  fetch_t               in_fetch,
    input  logic [xlen-1:0]      rs1_data,
    input  logic [xlen-1:0]      rs2_data,
    output logic [reg_idx_w-1:0] rs1_addr,
    output logic [reg_idx_w-1:0] rs2_addr,
    output exec_t                exec
);

    logic            valid_q;
    fetch_t          fetch_q;
    dec_t            dec;
    logic [xlen-1:0] opnd_a;
    logic [xlen-1:0] opnd_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            fetch_q <= in_fetch;   // held over idle cycles
        end
    end

    inst_decoder u_decoder (
        .inst (fetch_q.inst),
        .dec  (dec)
    );

    assign rs1_addr = dec.rs1;
    assign rs2_addr = dec.rs2;

    always_comb begin
        case (dec.a_sel)
            a_sel_pc:   opnd_a = fetch_q.pc;
            a_sel_zero: opnd_a = '0;
            default:    opnd_a = rs1_data;
        endcase

        case (dec.b_sel)
            b_sel_imm:   opnd_b = dec.imm;
            b_sel_shamt: opnd_b = {{(xlen-6){1'b0}}, dec.shamt};
            default:     opnd_b = rs2_data;
        endcase
    end

    always_comb begin
        exec.valid     = valid_q;
        exec.pc        = fetch_q.pc;
        exec.rd        = dec.rd;
        exec.a         = opnd_a;
        exec.b         = opnd_b;
        exec.alu_mode  = dec.alu_mode;
        exec.word_op   = dec.word_op;
        exec.writes_rd = valid_q & dec.writes_rd;   // no side effects from bubbles
        exec.sys       = valid_q ? dec.sys : sys_none;
        exec.illegal   = valid_q & dec.illegal;
    end

    // an unsupported encoding must never reach the register file
    illegal_no_write: assert property (@(posedge clk) disable iff (rst)
        exec.illegal |-> !exec.writes_rd)
        else $error("illegal instruction marked as writing rd");

endmodule

`default_nettype wire

/* verilog/inst_decoder.sv */
// combinational RV64I decoder for the integer subset, immediates and control fields
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
    import rv_pkg::*;
(
    input  logic [31:0] inst,
    output dec_t        dec
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic            legal;
    logic            rd_write;   // instruction class writes rd

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
    assign imm_u = {{(xlen-32){inst[31]}}, inst[31:12], 12'b0};

    always_comb begin
        dec           = '0;
        dec.alu_mode  = alu_add;
        dec.a_sel     = a_sel_rs1;
        dec.b_sel     = b_sel_rs2;
        dec.sys       = sys_none;
        dec.rd        = inst[11:7];
        dec.rs1       = inst[19:15];
        dec.rs2       = inst[24:20];
        dec.shamt     = inst[25:20];
        dec.imm       = imm_i;
        legal         = 1'b1;
        rd_write      = 1'b1;

        case (opcode)
            7'b0110011: begin   // op
                case ({funct7, funct3})
                    10'b0000000_000: dec.alu_mode = alu_add;
                    10'b0100000_000: dec.alu_mode = alu_sub;
                    10'b0000000_001: dec.alu_mode = alu_sll;
                    10'b0000000_010: dec.alu_mode = alu_slt;
                    10'b0000000_011: dec.alu_mode = alu_sltu;
                    10'b0000000_100: dec.alu_mode = alu_xor;
                    10'b0000000_101: dec.alu_mode = alu_srl;
                    10'b0100000_101: dec.alu_mode = alu_sra;
                    10'b0000000_110: dec.alu_mode = alu_or;
                    10'b0000000_111: dec.alu_mode = alu_and;
                    default:         legal = 1'b0;   // mul/div land here
                endcase
            end
            7'b0111011: begin   // op-32
                dec.word_op = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: dec.alu_mode = alu_add;
                    10'b0100000_000: dec.alu_mode = alu_sub;
                    10'b0000000_001: dec.alu_mode = alu_sll;
                    10'b0000000_101: dec.alu_mode = alu_srl;
                    10'b0100000_101: dec.alu_mode = alu_sra;
                    default:         legal = 1'b0;
                endcase
            end
            7'b0010011: begin   // op-imm
                dec.b_sel = b_sel_imm;
                case (funct3)
                    3'b000: dec.alu_mode = alu_add;
                    3'b010: dec.alu_mode = alu_slt;
                    3'b011: dec.alu_mode = alu_sltu;
                    3'b100: dec.alu_mode = alu_xor;
                    3'b110: dec.alu_mode = alu_or;
                    3'b111: dec.alu_mode = alu_and;
                    3'b001: begin
                        dec.b_sel    = b_sel_shamt;
                        dec.alu_mode = alu_sll;
                        legal        = (inst[31:26] == 6'b000000);
                    end
                    default: begin   // srli / srai, 6-bit shamt
                        dec.b_sel    = b_sel_shamt;
                        dec.alu_mode = inst[30] ? alu_sra : alu_srl;
                        legal        = ({inst[31], inst[29:26]} == 5'b00000);
                    end
                endcase
            end
            7'b0011011: begin   // op-imm-32
                dec.word_op = 1'b1;
                dec.b_sel   = b_sel_shamt;
                case ({funct7, funct3})
                    10'b0000000_001: dec.alu_mode = alu_sll;
                    10'b0000000_101: dec.alu_mode = alu_srl;
                    10'b0100000_101: dec.alu_mode = alu_sra;
                    default: begin
                        dec.b_sel = b_sel_imm;   // addiw
                        legal     = (funct3 == 3'b000);
                    end
                endcase
            end
            7'b0110111: begin   // lui
                dec.a_sel = a_sel_zero;
                dec.b_sel = b_sel_imm;
                dec.imm   = imm_u;
            end
            7'b0010111: begin   // auipc
                dec.a_sel = a_sel_pc;
                dec.b_sel = b_sel_imm;
                dec.imm   = imm_u;
            end
            7'b1110011: begin   // system, exact encodings only
                rd_write = 1'b0;
                case (inst)
                    32'h0000_0073: dec.sys = sys_ecall;
                    32'h0010_0073: dec.sys = sys_ebreak;
                    32'h3020_0073: dec.sys = sys_mret;
                    default:       legal = 1'b0;   // csr ops
                endcase
            end
            default: legal = 1'b0;   // branches, jumps, loads, stores
        endcase

        dec.illegal   = ~legal;
        dec.writes_rd = legal & rd_write & (inst[11:7] != '0);
    end

endmodule

`default_nettype wire

/* verilog/rv_pkg.sv */
// shared widths, ALU and operand-select enums, pipeline structs for the integer slice
`default_nettype none

package rv_pkg;

    localparam int xlen      = 64;   // data width
    localparam int nreg      = 32;   // architectural registers
    localparam int reg_idx_w = 5;    // register index width

    // ALU operation, shared by the 64-bit and word forms
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_mode_e;

    typedef enum logic [1:0] {
        a_sel_rs1,
        a_sel_pc,    // auipc
        a_sel_zero   // lui
    } a_sel_e;

    typedef enum logic [1:0] {
        b_sel_rs2,
        b_sel_imm,
        b_sel_shamt  // immediate shifts
    } b_sel_e;

    typedef enum logic [1:0] {
        sys_none,
        sys_ecall,
        sys_ebreak,
        sys_mret
    } sys_e;

    // instruction as presented by fetch
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0]     inst;
    } fetch_t;

    typedef struct packed {
        alu_mode_e            alu_mode;
        a_sel_e               a_sel;
        b_sel_e               b_sel;
        logic                 word_op;    // 32-bit op, result sign-extended
        logic [xlen-1:0]      imm;
        logic [5:0]           shamt;
        logic [reg_idx_w-1:0] rd;
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic                 writes_rd;
        sys_e                 sys;
        logic                 illegal;
    } dec_t;

    // decode to execute bundle
    typedef struct packed {
        logic                 valid;
        logic [xlen-1:0]      pc;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      a;
        logic [xlen-1:0]      b;
        alu_mode_e            alu_mode;
        logic                 word_op;
        logic                 writes_rd;
        sys_e                 sys;
        logic                 illegal;
    } exec_t;

    typedef struct packed {
        logic                 en;
        logic [reg_idx_w-1:0] addr;
        logic [xlen-1:0]      data;
    } wb_t;

    // one record per retired instruction
    typedef struct packed {
        logic                 valid;
        logic [xlen-1:0]      pc;
        logic [reg_idx_w-1:0] rd;
        logic                 wen;
        logic [xlen-1:0]      value;
        sys_e                 sys;
        logic                 illegal;
    } retire_t;

endpackage

`default_nettype wire
